//--- all.f
rtl/cache_pkg.sv
rtl/cache_way.sv
rtl/banked_mem.sv
rtl/cache_fsm.sv
rtl/cache_ctrl.sv
rtl/mem_system.sv
verification/mem_system_properties.sv
verification/mem_system_checker.sv
verification/mem_system_tb.sv

//--- verification/mem_system_tb.sv
`timescale 1ns/1ps

module mem_system_tb
	import cache_pkg::*;
;

	typedef enum logic [1:0] {
		op_read,
		op_write,
		op_both
	} op_e;

	// one stimulus line with its expected answer
	typedef struct packed {
		op_e op;
		addr_t addr;
		word_t wdata;
		word_t exp_data;
		logic exp_hit;
		logic exp_err;
	} entry_t;

	logic clk;
	logic rst_n;
	addr_t addr;
	word_t data_in;
	logic rd;
	logic wr;
	word_t data_out;
	logic done;
	logic stall;
	logic cache_hit;
	logic err;

	int test_id;
	word_t exp_data;
	logic exp_hit;
	logic exp_err;
	int tests_run;
	int tests_failed;
	int error_count;
	logic table_ready;

	entry_t table_q [$];

	// requester view of memory plus cache placement
	word_t ref_mem [mem_words];
	tag_t ref_tag [num_sets][2];
	logic ref_valid [num_sets][2];
	logic ref_victim;

	mem_system u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	mem_system_checker u_checker (
		.clk          (clk),
		.rst_n        (rst_n),
		.addr         (addr),
		.rd           (rd),
		.wr           (wr),
		.data_out     (data_out),
		.done         (done),
		.stall        (stall),
		.cache_hit    (cache_hit),
		.err          (err),
		.test_id      (test_id),
		.exp_data     (exp_data),
		.exp_hit      (exp_hit),
		.exp_err      (exp_err),
		.tests_run    (tests_run),
		.tests_failed (tests_failed),
		.error_count  (error_count)
	);

	bind cache_ctrl mem_system_properties u_props (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd       (rd),
		.wr       (wr),
		.done     (done),
		.err      (err),
		.stall    (stall),
		.fsm_busy (fsm_busy),
		.mem_req  (mem_req)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// word-aligned byte address of one word in a line
	function automatic addr_t line_addr(input tag_t t, input index_t idx, input logic [1:0] w);
		return {t, idx, w, 1'b0};
	endfunction

	task automatic add_entry(input op_e op, input addr_t a, input word_t wd, input word_t d,
			input logic h, input logic e);
		table_q.push_back({op, a, wd, d, h, e});
	endtask

	task automatic model_access(input entry_t ent, output word_t data, output logic hit,
			output logic bad);
		tag_t t;
		index_t idx;
		logic way;
		t = ent.addr[15:tag_lsb];
		idx = ent.addr[tag_lsb-1:index_lsb];
		data = '0;
		hit = 1'b0;
		// every pulse flips the victim bit, dropped ones too
		ref_victim = ~ref_victim;
		bad = (ent.op == op_both) || ent.addr[0];
		if (!bad) begin
			if (ref_valid[idx][0] && (ref_tag[idx][0] == t)) begin
				hit = 1'b1;
			end else if (ref_valid[idx][1] && (ref_tag[idx][1] == t)) begin
				hit = 1'b1;
			end else begin
				// empty way first, else the victim bit
				way = !ref_valid[idx][0] ? 1'b0 : (!ref_valid[idx][1] ? 1'b1 : ref_victim);
				ref_valid[idx][way] = 1'b1;
				ref_tag[idx][way] = t;
			end
			if (ent.op == op_write) begin
				ref_mem[ent.addr[15:1]] = ent.wdata;
			end else begin
				data = ref_mem[ent.addr[15:1]];
			end
		end
	endtask

	task automatic build_table();
		logic [31:0] seed;
		entry_t ent;
		word_t d;
		logic h;
		logic e;
		for (int i = 0; i < mem_words; i++) begin
			ref_mem[i] = '0;
		end
		for (int s = 0; s < num_sets; s++) begin
			ref_valid[s][0] = 1'b0;
			ref_valid[s][1] = 1'b0;
		end
		ref_victim = 1'b0;
		// fill one line dirty, then push it out with two other tags
		add_entry(op_write, line_addr(5'd2, 8'd9, 2'd1), 16'ha5a5, 16'h0000, 1'b0, 1'b0);
		add_entry(op_write, line_addr(5'd2, 8'd9, 2'd3), 16'h5a5a, 16'h0000, 1'b1, 1'b0);
		add_entry(op_read, line_addr(5'd3, 8'd9, 2'd0), 16'h0000, 16'h0000, 1'b0, 1'b0);
		add_entry(op_read, line_addr(5'd4, 8'd9, 2'd0), 16'h0000, 16'h0000, 1'b0, 1'b0);
		// miss brings back the written-back words
		add_entry(op_read, line_addr(5'd2, 8'd9, 2'd1), 16'h0000, 16'ha5a5, 1'b0, 1'b0);
		add_entry(op_read, line_addr(5'd2, 8'd9, 2'd3), 16'h0000, 16'h5a5a, 1'b1, 1'b0);
		add_entry(op_write, line_addr(5'd2, 8'd9, 2'd1), 16'h1234, 16'h0000, 1'b1, 1'b0);
		add_entry(op_read, line_addr(5'd2, 8'd9, 2'd1), 16'h0000, 16'h1234, 1'b1, 1'b0);
		// tags 4 and 2 share set 9
		add_entry(op_read, line_addr(5'd4, 8'd9, 2'd0), 16'h0000, 16'h0000, 1'b1, 1'b0);
		add_entry(op_read, line_addr(5'd2, 8'd9, 2'd1), 16'h0000, 16'h1234, 1'b1, 1'b0);
		add_entry(op_read, line_addr(5'd4, 8'd9, 2'd2), 16'h0000, 16'h0000, 1'b1, 1'b0);
		add_entry(op_read, line_addr(5'd2, 8'd9, 2'd3), 16'h0000, 16'h5a5a, 1'b1, 1'b0);
		// victim bit names way 1, tag 2 goes out dirty
		add_entry(op_read, line_addr(5'd6, 8'd9, 2'd0), 16'h0000, 16'h0000, 1'b0, 1'b0);
		add_entry(op_read, line_addr(5'd4, 8'd9, 2'd0), 16'h0000, 16'h0000, 1'b1, 1'b0);
		add_entry(op_read, line_addr(5'd2, 8'd9, 2'd1), 16'h0000, 16'h1234, 1'b0, 1'b0);
		// dropped requests
		add_entry(op_read, line_addr(5'd2, 8'd9, 2'd1) | 16'h1, 16'h0000, 16'h0000, 1'b0, 1'b1);
		add_entry(op_write, line_addr(5'd4, 8'd9, 2'd0) | 16'h1, 16'hbeef, 16'h0000, 1'b0, 1'b1);
		add_entry(op_both, line_addr(5'd4, 8'd9, 2'd0), 16'hdead, 16'h0000, 1'b0, 1'b1);
		add_entry(op_read, line_addr(5'd2, 8'd9, 2'd1), 16'h0000, 16'h1234, 1'b1, 1'b0);
		add_entry(op_read, line_addr(5'd4, 8'd9, 2'd0), 16'h0000, 16'h0000, 1'b1, 1'b0);
		// model walks the fixed part so the random part starts in step
		foreach (table_q[i]) begin
			model_access(table_q[i], d, h, e);
		end
		seed = 32'd92;
		repeat (40) begin
			seed = lcg_next(seed);
			ent.op = seed[28] ? op_write : op_read;
			// 12 tags over sets 40 to 43
			ent.addr = line_addr(tag_t'((seed >> 16) % 12), 8'd40 + index_t'(seed[13:12]),
				seed[9:8]);
			seed = lcg_next(seed);
			ent.wdata = seed[31:16];
			model_access(ent, d, h, e);
			ent.exp_data = d;
			ent.exp_hit = h;
			ent.exp_err = e;
			table_q.push_back(ent);
		end
	endtask

	// starts 1 ns after an edge, returns 1 ns after the done edge
	task automatic apply_entry(input entry_t ent, input int id);
		test_id = id;
		exp_data = ent.exp_data;
		exp_hit = ent.exp_hit;
		exp_err = ent.exp_err;
		addr = ent.addr;
		data_in = ent.wdata;
		rd = (ent.op != op_write);
		wr = (ent.op != op_read);
		@(posedge clk);
		#1;
		rd = 1'b0;
		wr = 1'b0;
		@(posedge clk);
		while (!done) begin
			@(posedge clk);
		end
		#1;
	endtask

	initial begin : watchdog
		wait (table_ready);
		repeat (table_q.size() * 60 + 8) @(posedge clk);
		$display("watchdog expired, a request never completed");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		test_id = 0;
		exp_data = '0;
		exp_hit = 1'b0;
		exp_err = 1'b0;
		table_ready = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		foreach (table_q[i]) begin
			apply_entry(table_q[i], i);
		end
		// let the checker take the last done
		repeat (2) @(posedge clk);
		$display("tests run %0d of %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, table_q.size(), tests_failed, error_count,
			u_dut.u_ctrl.u_props.fail_count);
		if ((tests_run == table_q.size()) && (tests_failed == 0) && (error_count == 0) &&
				(u_dut.u_ctrl.u_props.fail_count == 0)) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- verification/mem_system_checker.sv
`timescale 1ns/1ps

module mem_system_checker
	import cache_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t addr,
	input  logic  rd,
	input  logic  wr,
	input  word_t data_out,
	input  logic  done,
	input  logic  stall,
	input  logic  cache_hit,
	input  logic  err,
	input  int    test_id,
	input  word_t exp_data,
	input  logic  exp_hit,
	input  logic  exp_err,
	output int    tests_run,
	output int    tests_failed,
	output int    error_count
);

	// request under test is latched when its pulse is seen
	logic pending;
	int cycle;
	int req_cycle;
	int want_id;
	addr_t req_addr;
	logic req_rd;
	logic req_wr;
	word_t want_data;
	logic want_hit;
	logic want_err;

	task automatic report_mismatch(input string name, input logic [15:0] got,
			input logic [15:0] want);
		$display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, want);
		error_count++;
	endtask

	always @(posedge clk) begin
		int latency;
		int errors_before;
		string kind;
		if (!rst_n) begin
			pending = 1'b0;
			cycle = 0;
			tests_run = 0;
			tests_failed = 0;
			error_count = 0;
		end else begin
			cycle++;
			// stall covers the request cycle through the done cycle
			if (stall !== (pending || rd || wr)) begin
				report_mismatch("stall", stall, pending || rd || wr);
			end
			if (done && !pending) begin
				$display("at %0t ns done pulsed with no request outstanding", $time);
				error_count++;
			end else if (done) begin
				errors_before = error_count;
				latency = cycle - req_cycle;
				if (err !== want_err) begin
					report_mismatch("err", err, want_err);
				end
				if (!want_err) begin
					if (cache_hit !== want_hit) begin
						report_mismatch("cache_hit", cache_hit, want_hit);
					end
					// write data is not returned
					if (req_rd && (data_out !== want_data)) begin
						report_mismatch("data_out", data_out, want_data);
					end
				end
				// hits and dropped requests both take two cycles
				if ((want_hit || want_err) && (latency != 2)) begin
					$display("at %0t ns test %0d finished after %0d cycles instead of 2",
						$time, want_id, latency);
					error_count++;
				end
				kind = (req_rd && req_wr) ? "rd+wr" : (req_wr ? "write" : "read");
				tests_run++;
				if (error_count != errors_before) begin
					tests_failed++;
				end
				$display("test %0d %s addr %h latency %0d: %s", want_id, kind, req_addr,
					latency, (error_count != errors_before) ? "bad" : "ok");
				pending = 1'b0;
			end
			if (rd || wr) begin
				if (pending) begin
					$display("at %0t ns a request was issued before the previous one finished",
						$time);
					error_count++;
				end
				pending = 1'b1;
				req_cycle = cycle;
				want_id = test_id;
				req_addr = addr;
				req_rd = rd;
				req_wr = wr;
				want_data = exp_data;
				want_hit = exp_hit;
				want_err = exp_err;
			end
		end
	end

endmodule

//--- verification/mem_system_properties.sv
`timescale 1ns/1ps

module mem_system_properties
	import cache_pkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input logic     rd,
	input logic     wr,
	input logic     done,
	input logic     err,
	input logic     stall,
	input logic     fsm_busy,
	input mem_req_t mem_req
);

	// assertion failures so far
	int fail_count = 0;

	// request accepted and not yet completed
	logic open_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			open_q <= 1'b0;
		end else if (rd | wr) begin
			open_q <= 1'b1;
		end else if (done) begin
			open_q <= 1'b0;
		end
	end

	// done is a single-cycle pulse
	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
	else begin
		$error("done held high for more than one cycle");
		fail_count++;
	end

	// every cycle up to and including done
	stall_until_done: assert property (@(posedge clk) disable iff (!rst_n)
		open_q |-> stall)
	else begin
		$error("stall dropped before done");
		fail_count++;
	end

	// memory only sees strobes while the fsm works
	no_strobe_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!fsm_busy |-> !(mem_req.rd || mem_req.wr))
	else begin
		$error("memory strobe while the fsm is idle");
		fail_count++;
	end

	// both strobes together must come back as an error
	both_strobes_error: assert property (@(posedge clk) disable iff (!rst_n)
		(rd && wr) |-> ##2 (done && err))
	else begin
		$error("rd and wr together did not end in err");
		fail_count++;
	end

endmodule

//--- rtl/mem_system.sv
`timescale 1ns/1ps

module mem_system
	import cache_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t addr,
	input  word_t data_in,
	input  logic  rd,
	input  logic  wr,
	output word_t data_out,
	output logic  done,
	output logic  stall,
	output logic  cache_hit,
	output logic  err
);

	way_req_t way_0_req;
	way_req_t way_1_req;
	way_resp_t way_0_resp;
	way_resp_t way_1_resp;
	mem_req_t mem_req;
	mem_resp_t mem_resp;

	// controller with its fsm
	cache_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (addr),
		.data_in    (data_in),
		.rd         (rd),
		.wr         (wr),
		.way_0_resp (way_0_resp),
		.way_1_resp (way_1_resp),
		.way_0_req  (way_0_req),
		.way_1_req  (way_1_req),
		.mem_resp   (mem_resp),
		.mem_req    (mem_req),
		.data_out   (data_out),
		.done       (done),
		.cache_hit  (cache_hit),
		.err        (err),
		.stall      (stall)
	);

	// two ways of the set-associative cache
	cache_way u_way_0 (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (way_0_req),
		.resp  (way_0_resp)
	);

	cache_way u_way_1 (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (way_1_req),
		.resp  (way_1_resp)
	);

	// backing store
	banked_mem u_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (mem_req),
		.resp  (mem_resp)
	);

endmodule

//--- rtl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
	import cache_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  addr_t     addr,
	input  word_t     data_in,
	input  logic      rd,
	input  logic      wr,
	input  way_resp_t way_0_resp,
	input  way_resp_t way_1_resp,
	output way_req_t  way_0_req,
	output way_req_t  way_1_req,
	input  mem_resp_t mem_resp,
	output mem_req_t  mem_req,
	output word_t     data_out,
	output logic      done,
	output logic      cache_hit,
	output logic      err,
	output logic      stall
);

	// request held for the whole transaction
	addr_t addr_q;
	word_t data_in_q;
	logic rd_q;
	logic wr_q;

	// registered way answers
	way_resp_t way_0_q;
	way_resp_t way_1_q;
	way_resp_t way_merged;

	logic victim_q;
	logic cmp_cycle_q;
	logic sel_comb;
	logic sel_q;
	logic sel;
	logic fsm_busy;
	way_req_t way_req;

	always_ff @(posedge clk) begin
		if (rd | wr) begin
			addr_q <= addr;
			data_in_q <= data_in;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
			way_0_q <= '0;
			way_1_q <= '0;
			victim_q <= 1'b0;
			cmp_cycle_q <= 1'b0;
			sel_q <= 1'b0;
		end else begin
			rd_q <= rd;
			wr_q <= wr;
			way_0_q <= way_0_resp;
			way_1_q <= way_1_resp;
			// flips on every request pulse
			victim_q <= victim_q ^ (rd | wr);
			// cycle where fsm sits in its compare state
			cmp_cycle_q <= rd_q | wr_q;
			if (cmp_cycle_q) begin
				sel_q <= sel_comb;
			end
		end
	end

	// empty way first, else the victim bit
	assign sel_comb = !way_0_q.valid ? 1'b0 :
			!way_1_q.valid ? 1'b1 : victim_q;
	// choice is live in the compare cycle, latched after
	assign sel = cmp_cycle_q ? sel_comb : sel_q;

	// hitting way wins, else the chosen way
	always_comb begin
		if (way_1_q.hit) begin
			way_merged = way_1_q;
		end else if (way_0_q.hit) begin
			way_merged = way_0_q;
		end else begin
			way_merged = sel ? way_1_q : way_0_q;
		end
	end

	// compares go to both ways, everything else to the chosen one
	always_comb begin
		way_0_req = way_req;
		way_1_req = way_req;
		way_0_req.enable = way_req.enable & (way_req.comp | ~sel);
		way_1_req.enable = way_req.enable & (way_req.comp | sel);
	end

	// from request pulse through the done cycle
	assign stall = rd | wr | rd_q | wr_q | fsm_busy;

	cache_fsm u_fsm (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd        (rd_q),
		.wr        (wr_q),
		.addr      (addr_q),
		.data_in   (data_in_q),
		.way       (way_merged),
		.mem       (mem_resp),
		.way_req   (way_req),
		.mem_req   (mem_req),
		.data_out  (data_out),
		.done      (done),
		.cache_hit (cache_hit),
		.err       (err),
		.busy      (fsm_busy)
	);

endmodule

//--- rtl/cache_fsm.sv
`timescale 1ns/1ps

module cache_fsm
	import cache_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      rd,
	input  logic      wr,
	input  addr_t     addr,
	input  word_t     data_in,
	input  way_resp_t way,
	input  mem_resp_t mem,
	output way_req_t  way_req,
	output mem_req_t  mem_req,
	output word_t     data_out,
	output logic      done,
	output logic      cache_hit,
	output logic      err,
	output logic      busy
);

	ctrl_state_e state;
	ctrl_state_e next_state;
	ctrl_state_e step_next;

	// word returned to the requester after a refill
	word_t data_q;
	logic write_op;

	// refill words in flight from memory
	logic [mem_latency-1:0] ret_valid;
	logic [1:0] ret_word [mem_latency];

	tag_t req_tag;
	index_t req_index;
	logic bad_req;
	logic rd_accept;
	logic [1:0] step_word;

	assign req_tag = addr[15:tag_lsb];
	assign req_index = addr[tag_lsb-1:index_lsb];
	// odd address or both strobes
	assign bad_req = (rd & wr) | ((rd | wr) & addr[0]);
	assign busy = (state != idle);
	// hit data comes straight from the way
	assign data_out = (state == comp_read) ? way.data : data_q;

	// word index and successor of each evict and fill step
	always_comb begin
		step_word = 2'd0;
		step_next = idle;
		unique case (state)
			evict_0: step_next = evict_1;
			evict_1: begin
				step_word = 2'd1;
				step_next = evict_2;
			end
			evict_2: begin
				step_word = 2'd2;
				step_next = evict_3;
			end
			evict_3: begin
				step_word = 2'd3;
				step_next = fill_0;
			end
			fill_0: step_next = fill_1;
			fill_1: begin
				step_word = 2'd1;
				step_next = fill_2;
			end
			fill_2: begin
				step_word = 2'd2;
				step_next = fill_3;
			end
			fill_3: begin
				step_word = 2'd3;
				step_next = fill_wait;
			end
			default: step_next = idle;
		endcase
	end

	always_comb begin
		next_state = state;
		done = 1'b0;
		cache_hit = 1'b0;
		err = 1'b0;
		rd_accept = 1'b0;
		way_req = '0;
		way_req.tag = req_tag;
		way_req.index = req_index;
		way_req.offset = addr[index_lsb-1:0];
		way_req.data = data_in;
		mem_req = '0;
		mem_req.addr = addr;
		mem_req.data = way.data;
		// refill word arriving from memory
		if (ret_valid[mem_latency-1]) begin
			way_req.enable = 1'b1;
			way_req.write = 1'b1;
			way_req.valid_in = 1'b1;
			way_req.offset = {ret_word[mem_latency-1], 1'b0};
			way_req.data = mem.data;
		end
		unique case (state)
			idle: begin
				if (bad_req) begin
					next_state = error_done;
				end else if (rd | wr) begin
					// both ways compare, a write lands only on the hit way
					way_req.enable = 1'b1;
					way_req.comp = 1'b1;
					way_req.write = wr;
					next_state = wr ? comp_write : comp_read;
				end
			end
			comp_read, comp_write: begin
				if (way.hit) begin
					done = 1'b1;
					cache_hit = 1'b1;
					next_state = idle;
				end else begin
					// fetch victim word 0 ahead of eviction
					way_req.enable = 1'b1;
					way_req.offset = '0;
					next_state = (way.valid & way.dirty) ? evict_0 : fill_0;
				end
			end
			evict_0, evict_1, evict_2, evict_3: begin
				mem_req.wr = 1'b1;
				mem_req.addr = {way.tag, req_index, step_word, 1'b0};
				way_req.enable = 1'b1;
				if (mem.err) begin
					next_state = error_done;
				end else if (mem.stall) begin
					// reread the same word for the repeated strobe
					way_req.offset = {step_word, 1'b0};
				end else begin
					way_req.offset = {step_word + 2'd1, 1'b0};
					next_state = step_next;
				end
			end
			fill_0, fill_1, fill_2, fill_3: begin
				mem_req.rd = 1'b1;
				mem_req.addr = {req_tag, req_index, step_word, 1'b0};
				if (mem.err) begin
					next_state = error_done;
				end else if (!mem.stall) begin
					rd_accept = 1'b1;
					next_state = step_next;
				end
			end
			fill_wait: begin
				// last word is written in the cycle we leave
				if (ret_valid[mem_latency-2:0] == '0) begin
					next_state = retry;
				end
			end
			retry: begin
				way_req.enable = 1'b1;
				way_req.comp = 1'b1;
				way_req.write = write_op;
				done = 1'b1;
				next_state = idle;
			end
			error_done: begin
				done = 1'b1;
				err = 1'b1;
				next_state = idle;
			end
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			write_op <= 1'b0;
			ret_valid <= '0;
		end else begin
			state <= next_state;
			if ((state == idle) && (rd | wr)) begin
				write_op <= wr;
			end
			ret_valid[0] <= rd_accept;
			for (int i = 1; i < mem_latency; i++) begin
				ret_valid[i] <= ret_valid[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		ret_word[0] <= step_word;
		for (int i = 1; i < mem_latency; i++) begin
			ret_word[i] <= ret_word[i-1];
		end
		// keep the requested word as it streams by
		if (ret_valid[mem_latency-1] && (ret_word[mem_latency-1] == addr[2:1])) begin
			data_q <= mem.data;
		end
	end

endmodule

//--- rtl/banked_mem.sv
`timescale 1ns/1ps

module banked_mem
	import cache_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  mem_req_t  req,
	output mem_resp_t resp
);

	word_t mem_array [mem_words];

	// busy countdown per bank
	logic [2:0] busy_cnt [words_per_line];

	// read return pipeline
	word_t data_pipe [mem_latency];
	logic [mem_latency-2:0] rd_pipe;

	logic [14:0] word_addr;
	bank_t bank;
	logic strobe;
	logic bank_busy;
	logic accept;

	// memory powers up cleared
	initial begin
		for (int i = 0; i < mem_words; i++) begin
			mem_array[i] = '0;
		end
	end

	assign word_addr = req.addr[15:1];
	// word interleaved, neighbouring words hit different banks
	assign bank = req.addr[2:1];
	assign strobe = req.rd | req.wr;
	assign bank_busy = (busy_cnt[bank] != '0);

	// range check on the word address
	assign resp.err = strobe & (int'(word_addr) >= mem_words);
	// refused strobe, requester repeats it
	assign resp.stall = strobe & bank_busy;
	assign accept = strobe & ~bank_busy & ~resp.err;
	assign resp.data = data_pipe[mem_latency-1];

	always_comb begin
		for (int b = 0; b < words_per_line; b++) begin
			resp.busy[b] = (busy_cnt[b] != '0);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_pipe <= '0;
			for (int b = 0; b < words_per_line; b++) begin
				busy_cnt[b] <= '0;
			end
		end else begin
			rd_pipe[0] <= accept & req.rd;
			for (int i = 1; i < mem_latency - 1; i++) begin
				rd_pipe[i] <= rd_pipe[i-1];
			end
			// reload on access, otherwise count down
			for (int b = 0; b < words_per_line; b++) begin
				if (accept && (bank == bank_t'(b))) begin
					busy_cnt[b] <= 3'(bank_busy_cycles);
				end else if (busy_cnt[b] != '0) begin
					busy_cnt[b] <= busy_cnt[b] - 3'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept & req.wr) begin
			mem_array[word_addr] <= req.data;
		end
		// first stage reads the array
		if (accept & req.rd) begin
			data_pipe[0] <= mem_array[word_addr];
		end
		// later stages advance behind their valid bit
		for (int i = 1; i < mem_latency; i++) begin
			if (rd_pipe[i-1]) begin
				data_pipe[i] <= data_pipe[i-1];
			end
		end
	end

endmodule

//--- rtl/cache_way.sv
`timescale 1ns/1ps

module cache_way
	import cache_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  way_req_t  req,
	output way_resp_t resp
);

	// per-set tag and line storage
	tag_t tag_mem [num_sets];
	word_t data_mem [num_sets][words_per_line];

	// per-set state bits
	logic [num_sets-1:0] valid_q;
	logic [num_sets-1:0] dirty_q;

	logic [1:0] word_sel;
	logic tag_match;
	logic write_hit;
	logic fill_write;

	// word within the line, offset bit zero ignored
	assign word_sel = req.offset[2:1];
	assign tag_match = (tag_mem[req.index] == req.tag);

	// lookup is purely combinational
	assign resp.hit = req.enable & req.comp & valid_q[req.index] & tag_match;
	assign resp.valid = valid_q[req.index];
	assign resp.dirty = dirty_q[req.index];
	assign resp.tag = tag_mem[req.index];
	assign resp.data = data_mem[req.index][word_sel];

	// compare write only lands on a hit
	assign write_hit = req.enable & req.write & resp.hit;
	// access write, used by refill
	assign fill_write = req.enable & req.write & ~req.comp;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (fill_write) begin
			// refilled line starts clean
			valid_q[req.index] <= req.valid_in;
			dirty_q[req.index] <= 1'b0;
		end else if (write_hit) begin
			dirty_q[req.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		// tag only changes on refill
		if (fill_write) begin
			tag_mem[req.index] <= req.tag;
		end
		if (fill_write | write_hit) begin
			data_mem[req.index][word_sel] <= req.data;
		end
	end

endmodule

//--- rtl/cache_pkg.sv
package cache_pkg;

	// byte address layout is tag | index | offset
	localparam int tag_lsb = 11;
	localparam int index_lsb = 3;

	// cache and memory geometry
	localparam int num_sets = 256;
	localparam int words_per_line = 4;
	localparam int mem_words = 32768;
	// cycles from accepted read strobe to data
	localparam int mem_latency = 2;
	// cycles a bank stays busy after any access
	localparam int bank_busy_cycles = 4;

	typedef logic [15:0] word_t;
	typedef logic [15:0] addr_t;
	typedef logic [4:0] tag_t;
	typedef logic [7:0] index_t;
	typedef logic [2:0] offset_t;
	// bank select, address bits two and one
	typedef logic [1:0] bank_t;

	// control bundle for one way
	typedef struct packed {
		logic enable;
		logic comp;
		logic write;
		logic valid_in;
		tag_t tag;
		index_t index;
		offset_t offset;
		word_t data;
	} way_req_t;

	typedef struct packed {
		logic hit;
		logic dirty;
		logic valid;
		tag_t tag;
		word_t data;
	} way_resp_t;

	typedef struct packed {
		logic wr;
		logic rd;
		addr_t addr;
		word_t data;
	} mem_req_t;

	// one busy flag per bank
	typedef struct packed {
		word_t data;
		logic [words_per_line-1:0] busy;
		logic stall;
		logic err;
	} mem_resp_t;

	typedef enum logic [3:0] {
		idle,
		comp_read,
		comp_write,
		evict_0,
		evict_1,
		evict_2,
		evict_3,
		fill_0,
		fill_1,
		fill_2,
		fill_3,
		fill_wait,
		retry,
		error_done
	} ctrl_state_e;

endpackage
